//--- pcie_tx_stream.f
+incdir+.
pcie_tx_pkg.sv
tlp_header_decode.sv
payload_align.sv
stream_word_builder.sv
tx_stream_buffer.sv
pcie_tx_stream.sv
tb_pcie_tx_stream.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_pcie_tx_stream \
   -f pcie_tx_stream.f -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { cat build.log; echo "compile or run failed"; exit 1; }
cat sim.log
grep -q 'All tests passed!' sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tb_pcie_tx_stream.sv
// runs from a fixed LFSR seed; the stream is compared only after each group of packets drains
`timescale 1ns/1ps
`include "pcie_tx_macros.svh"

module tb_pcie_tx_stream
   import pcie_tx_pkg::*;
();

   // packet counts per test that set the run limit
   localparam int N3_PKTS = 18;
   localparam int N4_PKTS = 12;
   localparam int N5_PKTS = 8;
   localparam int MAX_LEN = 40;
   // upper bound on header, pad and payload DWs over all tests
   localparam int TOTAL_DW = 4 * 4 + N3_PKTS * (4 + 1 + 9) + (N4_PKTS + N5_PKTS) * (5 + MAX_LEN);
   localparam int CYCLE_LIMIT = TOTAL_DW * 4 + 2000;
   localparam int HOLD_CYCLES = 20;

   logic         clk_in = 1'b0;
   logic         rstn = 1'b0;
   logic         tx_req = 1'b0;
   word_t        tx_desc = '0;
   logic         tx_err = 1'b0;
   logic         tx_dv = 1'b0;
   word_t        tx_data = '0;
   logic         tx_stream_ready = 1'b0;
   logic         tx_ack;
   logic         tx_ws;
   logic         tx_stream_valid;
   stream_word_t tx_stream_data;
   logic         tx_fifo_empty;

   // mode 0 holds ready low and mode 1 holds it high
   // mode 2 draws it from its own LFSR
   logic [1:0]   rdy_mode = 2'd1;
   logic [31:0]  lfsr = 32'had57_01a8;
   logic [31:0]  rdy_lfsr = 32'had57_01a8;
   int           cycles = 0;
   int           errors = 0;
   int           test_errs = 0;
   int           tests_run = 0;
   int           tests_failed = 0;
   stream_word_t exp_q[$];
   stream_word_t got_q[$];
   dw_t          pay_q[$];
   word_t        beat_q[$];

   pcie_tx_stream i_pcie_tx_stream (
      .clk_in          (clk_in),
      .rstn            (rstn),
      .tx_req          (tx_req),
      .tx_desc         (tx_desc),
      .tx_err          (tx_err),
      .tx_dv           (tx_dv),
      .tx_data         (tx_data),
      .tx_stream_ready (tx_stream_ready),
      .tx_ack          (tx_ack),
      .tx_ws           (tx_ws),
      .tx_stream_valid (tx_stream_valid),
      .tx_stream_data  (tx_stream_data),
      .tx_fifo_empty   (tx_fifo_empty)
   );

   always #20 clk_in = ~clk_in;

   // ----------------------------------------
   // random source
   // ----------------------------------------

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // ----------------------------------------
   // ready driver, collector, watchdog
   // ----------------------------------------

   always @(posedge clk_in) begin
      if (rdy_mode == 2'd2) begin
         rdy_lfsr = lfsr_next(rdy_lfsr);
         tx_stream_ready <= rdy_lfsr[0];
      end else begin
         tx_stream_ready <= rdy_mode[0];
      end
   end

   // a transfer seen at the falling edge completes at the next rising edge
   always @(negedge clk_in) begin
      if (rstn && tx_stream_valid && tx_stream_ready)
         got_q.push_back(tx_stream_data);
   end

   always @(posedge clk_in) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout at %0t: run did not finish within %0d cycles", $time, CYCLE_LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   // ----------------------------------------
   // reference packer
   // ----------------------------------------

   // header DWs, optional zero pad, payload, cut into words with the first DW on top
   task automatic pack_expected(input word_t desc, input logic err);
      dw_t          seq[$];
      stream_word_t w;
      int           n_hdr;
      logic         b2;
      logic         pad;
      n_hdr = desc[`DESC_4DW_BIT] ? 4 : 3;
      for (int i = 0; i < n_hdr; i++)
         seq.push_back(desc[127-32*i -: 32]);
      // address bit 2 from dw2 (bit 34) or dw3 (bit 2)
      b2  = desc[`DESC_4DW_BIT] ? desc[2] : desc[34];
      pad = desc[`DESC_4DW_BIT] ? b2 : ~b2;
      if (desc[`DESC_HAS_PAYLOAD_BIT]) begin
         if (pad)
            seq.push_back('0);
         foreach (pay_q[i])
            seq.push_back(pay_q[i]);
      end
      for (int i = 0; i < seq.size(); i += 4) begin
         w.data = '0;
         for (int k = 0; k < 4 && i + k < seq.size(); k++)
            w.data[127-32*k -: 32] = seq[i+k];
         w.err   = err;
         w.sop   = (i == 0);
         w.eop   = (i + 4 >= seq.size());
         w.empty = w.eop && (seq.size() - i <= 2);
         exp_q.push_back(w);
      end
   endtask

   // ----------------------------------------
   // DMA side driver
   // ----------------------------------------

   task automatic send_packet(input word_t desc, input logic err);
      int idx;
      @(posedge clk_in);
      tx_req  <= 1'b1;
      tx_desc <= desc;
      tx_err  <= err;
      do begin
         @(negedge clk_in);
      end while (!tx_ack);
      @(posedge clk_in);
      tx_req <= 1'b0;
      idx = 0;
      if (beat_q.size() != 0) begin
         tx_dv   <= 1'b1;
         tx_data <= beat_q[0];
         while (idx < beat_q.size()) begin
            @(negedge clk_in);
            // beat held while the wait state is up
            if (!tx_ws)
               idx++;
            @(posedge clk_in);
            if (idx == beat_q.size())
               tx_dv <= 1'b0;
            else
               tx_data <= beat_q[idx];
         end
      end
   endtask

   // random header fields, payload and junk past the end of the last beat
   task automatic make_packet(input logic is4, input logic b2, input logic has_pay,
                              input int len);
      word_t       desc;
      word_t       beat;
      logic [31:0] r;
      pay_q.delete();
      beat_q.delete();
      for (int i = 0; i < 4; i++)
         desc[32*i +: 32] = rand_bits(32);
      desc[127] = 1'b0;
      desc[`DESC_HAS_PAYLOAD_BIT] = has_pay;
      desc[`DESC_4DW_BIT] = is4;
      desc[`DESC_LEN_LSB +: `DESC_LEN_W] = tlp_len_t'(len);
      if (is4)
         desc[2] = b2;
      else
         desc[34] = b2;
      r = rand_bits(1);
      if (has_pay) begin
         for (int i = 0; i < len; i++)
            pay_q.push_back(rand_bits(32));
      end
      for (int i = 0; i < pay_q.size(); i += 4) begin
         for (int k = 0; k < 4; k++)
            beat[32*k +: 32] = (i + k < pay_q.size()) ? pay_q[i+k] : rand_bits(32);
         beat_q.push_back(beat);
      end
      pack_expected(desc, r[0]);
      send_packet(desc, r[0]);
   endtask

   // ----------------------------------------
   // checking and reporting
   // ----------------------------------------

   task automatic report_test(input string name);
      tests_run++;
      if (test_errs != 0)
         tests_failed++;
      $display("%-16s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
   endtask

   task automatic compare_stream(input string name);
      int n;
      while (got_q.size() < exp_q.size())
         @(negedge clk_in);
      // output stage empty again before the count is taken
      while (!(tx_fifo_empty && !tx_stream_valid))
         @(negedge clk_in);
      assert (got_q.size() == exp_q.size()) else begin
         $display("Mismatch at %0t: %s got %0d words, expected %0d", $time, name,
                  got_q.size(), exp_q.size());
         errors++;
         test_errs++;
      end
      n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      for (int i = 0; i < n; i++) begin
         assert (got_q[i] === exp_q[i]) else begin
            $display("Mismatch at %0t: %s word %0d got %h, expected %h", $time, name, i,
                     got_q[i], exp_q[i]);
            errors++;
            test_errs++;
         end
      end
      got_q.delete();
      exp_q.delete();
      report_test(name);
   endtask

   // ----------------------------------------
   // tests
   // ----------------------------------------

   task automatic reset_values();
      test_errs = 0;
      @(negedge clk_in);
      assert (!tx_ack && !tx_ws && !tx_stream_valid && tx_fifo_empty) else begin
         $display("Mismatch at %0t: after reset ack %b ws %b valid %b empty %b", $time,
                  tx_ack, tx_ws, tx_stream_valid, tx_fifo_empty);
         errors++;
         test_errs++;
      end
      report_test("reset values");
   endtask

   // read-like headers with the length field set and no payload bit
   // both address alignments so a stray pad or carry shows up
   task automatic header_only_packets();
      test_errs = 0;
      for (int b2 = 0; b2 < 2; b2++) begin
         make_packet(1'b0, b2[0], 1'b0, 5);
         make_packet(1'b1, b2[0], 1'b0, 8);
      end
      compare_stream("header only");
   endtask

   task automatic three_dw_payloads();
      test_errs = 0;
      for (int b2 = 0; b2 < 2; b2++) begin
         for (int len = 1; len <= 9; len++)
            make_packet(1'b0, b2[0], 1'b1, len);
      end
      compare_stream("3DW payload");
   endtask

   task automatic four_dw_queue();
      logic [31:0] r;
      test_errs = 0;
      for (int i = 0; i < N4_PKTS; i++) begin
         r = rand_bits(6);
         make_packet(1'b1, i[0], 1'b1, 1 + int'(r % MAX_LEN));
      end
      compare_stream("4DW queue");
   endtask

   task automatic backpressure_drain();
      test_errs = 0;
      @(posedge clk_in);
      rdy_mode <= 2'd0;
      fork
         begin
            logic [31:0] r;
            for (int i = 0; i < N5_PKTS; i++) begin
               r = rand_bits(6);
               make_packet(r[5], r[4], 1'b1, 30 + int'(r[3:0] % 11));
            end
         end
         begin
            stream_word_t first_word;
            // buffer fills with ready low until the wait state comes up
            do begin
               @(negedge clk_in);
            end while (!tx_ws);
            first_word = tx_stream_data;
            for (int c = 0; c < HOLD_CYCLES; c++) begin
               @(negedge clk_in);
               assert (tx_ws && tx_stream_valid && !tx_fifo_empty &&
                       tx_stream_data === first_word) else begin
                  $display("Mismatch at %0t: output, wait state or empty flag moved %s",
                           $time, "with ready low");
                  errors++;
                  test_errs++;
               end
            end
            @(posedge clk_in);
            rdy_mode <= 2'd2;
         end
      join
      compare_stream("back-pressure");
   endtask

   initial begin
      repeat (2) @(posedge clk_in);
      rstn <= 1'b1;
      reset_values();
      header_only_packets();
      three_dw_payloads();
      four_dw_queue();
      backpressure_drain();
      $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
               errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- pcie_tx_stream.sv
// tx_desc and tx_err must hold from tx_req to tx_ack; payload beats only after tx_ack
`timescale 1ns/1ps

module pcie_tx_stream
   import pcie_tx_pkg::*;
(
   input  logic         clk_in,
   input  logic         rstn,
   input  logic         tx_req,
   input  word_t        tx_desc,
   input  logic         tx_err,
   input  logic         tx_dv,
   input  word_t        tx_data,
   input  logic         tx_stream_ready,
   output logic         tx_ack,
   output logic         tx_ws,
   output logic         tx_stream_valid,
   output stream_word_t tx_stream_data,
   output logic         tx_fifo_empty
);

   hdr_info_t    hdr;
   dw_count_t    dw_left;
   logic         busy;
   logic         start;
   word_t        pay_word;
   logic         pay_valid;
   logic         wr;
   stream_word_t wr_word;

   // ----------------------------------------
   // header and payload side by side
   // ----------------------------------------

   tlp_header_decode i_header_decode (
      .clk_in  (clk_in),
      .rstn    (rstn),
      .ack     (tx_ack),
      .desc    (tx_desc),
      .err     (tx_err),
      .word_wr (wr),
      .hdr     (hdr),
      .dw_left (dw_left),
      .busy    (busy)
   );

   payload_align i_payload_align (
      .clk_in     (clk_in),
      .rstn       (rstn),
      .data       (tx_data),
      .dv         (tx_dv),
      .ws         (tx_ws),
      .carry_dws  (hdr.carry_dws),
      .is_4dw     (hdr.is_4dw),
      .pad        (hdr.pad),
      .start      (start),
      .dw_left    (dw_left),
      .word       (pay_word),
      .word_valid (pay_valid)
   );

   // ----------------------------------------
   // word assembly and output buffer
   // ----------------------------------------

   stream_word_builder i_word_builder (
      .clk_in    (clk_in),
      .rstn      (rstn),
      .req       (tx_req),
      .ws        (tx_ws),
      .busy      (busy),
      .hdr       (hdr),
      .dw_left   (dw_left),
      .pay_word  (pay_word),
      .pay_valid (pay_valid),
      .ack       (tx_ack),
      .start     (start),
      .wr        (wr),
      .wr_word   (wr_word)
   );

   tx_stream_buffer i_stream_buffer (
      .clk_in    (clk_in),
      .rstn      (rstn),
      .wr        (wr),
      .wr_word   (wr_word),
      .ready     (tx_stream_ready),
      .ws        (tx_ws),
      .buf_empty (tx_fifo_empty),
      .valid     (tx_stream_valid),
      .data      (tx_stream_data)
   );

endmodule

//--- tx_stream_buffer.sv
// no overflow guard, writers must stop on ws; words written after ws rises must fit the margin
`timescale 1ns/1ps
`include "pcie_tx_macros.svh"

module tx_stream_buffer
   import pcie_tx_pkg::*;
(
   input  logic         clk_in,
   input  logic         rstn,
   input  logic         wr,
   input  stream_word_t wr_word,
   input  logic         ready,
   output logic         ws,
   output logic         buf_empty,
   output logic         valid,
   output stream_word_t data
);

   localparam int PTR_W = $clog2(`TX_BUF_DEPTH);
   localparam logic [PTR_W:0] AFULL = (PTR_W+1)'(`TX_BUF_AFULL);

   stream_word_t     mem [`TX_BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // one bit wider than the pointers so a full buffer is seen
   logic [PTR_W:0]   fill;
   logic             rd;

   assign buf_empty = (fill == '0);

   // refill the output register when it is free or being taken this cycle
   assign rd = ~buf_empty & (~valid | ready);

   // ----------------------------------------
   // storage and output register
   // ----------------------------------------

   always_ff @(posedge clk_in) begin
      if (wr)
         mem[wr_ptr] <= wr_word;
      if (rd)
         data <= mem[rd_ptr];
   end

   // ----------------------------------------
   // pointers, fill and flags
   // ----------------------------------------

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         ws     <= 1'b0;
         valid  <= 1'b0;
      end else begin
         // pointers wrap on their own
         if (wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= rd_ptr + 1'b1;
         fill <= fill + {{PTR_W{1'b0}}, wr} - {{PTR_W{1'b0}}, rd};
         // wait state follows the registered fill, one cycle late
         ws <= (fill >= AFULL);
         // valid holds while ready is low
         if (rd)
            valid <= 1'b1;
         else if (ready)
            valid <= 1'b0;
      end
   end

endmodule

//--- stream_word_builder.sv
// tx_req must stay high until ack; a new packet waits for the last write of the previous one
`timescale 1ns/1ps
`include "pcie_tx_macros.svh"

module stream_word_builder
   import pcie_tx_pkg::*;
(
   input  logic         clk_in,
   input  logic         rstn,
   input  logic         req,
   input  logic         ws,
   input  logic         busy,
   input  hdr_info_t    hdr,
   input  dw_count_t    dw_left,
   input  word_t        pay_word,
   input  logic         pay_valid,
   output logic         ack,
   output logic         start,
   output logic         wr,
   output stream_word_t wr_word
);

   localparam dw_count_t WORD_DWS = dw_count_t'(`TX_DW_PER_WORD);

   logic      req_seen;
   logic      hdr_vld;
   logic      first_pend;
   logic      hdr_src;
   logic      src;
   dw_count_t left_now;
   logic      last;
   word_t     src_data;

   // ----------------------------------------
   // request and acknowledge
   // ----------------------------------------

   // registered request, dropped right after ack so one request gives one ack
   assign ack = req_seen & ~ws & ~busy;

   // decoder output is valid the cycle after ack
   assign start = hdr_vld & hdr.has_payload;

   // ----------------------------------------
   // word sources
   // ----------------------------------------

   // header goes alone unless payload dw0 has to join it
   assign hdr_src = hdr_vld & ~hdr.carry_dws;
   assign src     = hdr_src | pay_valid;

   // count as it stands after the write now on the bus
   assign left_now = wr ? ((dw_left > WORD_DWS) ? dw_left - WORD_DWS : '0) : dw_left;
   assign last     = (left_now <= WORD_DWS);

   // first aligned word of a carry packet has zeros where the header sits
   always_comb begin
      if (hdr_src)
         src_data = hdr.hdr_word;
      else if (first_pend)
         src_data = hdr.hdr_word | pay_word;
      else
         src_data = pay_word;
   end

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         req_seen   <= 1'b0;
         hdr_vld    <= 1'b0;
         first_pend <= 1'b0;
         wr         <= 1'b0;
      end else begin
         req_seen <= ack ? 1'b0 : req;
         hdr_vld  <= ack;
         wr       <= src;
         if (hdr_vld)
            first_pend <= hdr.carry_dws;
         else if (pay_valid)
            first_pend <= 1'b0;
      end
   end

   // ----------------------------------------
   // buffer entry
   // ----------------------------------------

   always_ff @(posedge clk_in) begin
      if (src) begin
         wr_word.err   <= hdr.err;
         wr_word.sop   <= hdr_src | first_pend;
         wr_word.eop   <= last;
         // on the last word left_now is its valid DW count
         wr_word.empty <= last & (left_now <= dw_count_t'(2));
         wr_word.data  <= src_data;
      end
   end

endmodule

//--- payload_align.sv
// expects exactly the beats the length needs; a beat past the packet end is dropped
`timescale 1ns/1ps
`include "pcie_tx_macros.svh"

module payload_align
   import pcie_tx_pkg::*;
(
   input  logic      clk_in,
   input  logic      rstn,
   input  word_t     data,
   input  logic      dv,
   input  logic      ws,
   input  logic      carry_dws,
   input  logic      is_4dw,
   input  logic      pad,
   input  logic      start,
   input  dw_count_t dw_left,
   output word_t     word,
   output logic      word_valid
);

   localparam dw_count_t WORD_DWS = dw_count_t'(`TX_DW_PER_WORD);

   logic [1:0] skew;
   logic       active;
   logic       flush;
   word_t      held;
   dw_count_t  owed;
   logic       act;
   word_t      held_e;
   dw_count_t  owed_e;
   dw_count_t  owed_nxt;
   logic       take;

   // reorder to stream order and zero the DWs past the packet end
   // sh is the number of DWs that ride over from the previous beat
   function automatic word_t align_word(word_t prev, word_t cur, logic [1:0] sh,
                                        dw_count_t n);
      word_t w;
      case (sh)
         2'd1:    w = {prev[127:96], cur[31:0], cur[63:32], cur[95:64]};
         2'd3:    w = {prev[63:32], prev[95:64], prev[127:96], cur[31:0]};
         default: w = {cur[31:0], cur[63:32], cur[95:64], cur[127:96]};
      endcase
      for (int i = 0; i < `TX_DW_PER_WORD; i++) begin
         if (n <= dw_count_t'(i))
            w[127-32*i -: 32] = dw_t'(0);
      end
      return w;
   endfunction

   // 3 when dw0 shares the 3DW header word, 1 behind the pad of a 4DW header
   assign skew = carry_dws ? 2'd3 : ((is_4dw & pad) ? 2'd1 : 2'd0);

   // a beat may arrive in the same cycle as start
   assign act    = start | active;
   // start clears the holdover, those zeros become header slots or the pad
   assign held_e = start ? '0 : held;
   // a header word written on its own is not counted here
   assign owed_e = start ? (carry_dws ? dw_left : dw_left - WORD_DWS) : owed;
   assign take   = act & ~flush & dv & ~ws;

   assign owed_nxt = (owed_e > WORD_DWS) ? owed_e - WORD_DWS : '0;

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         active     <= 1'b0;
         flush      <= 1'b0;
         owed       <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= take | flush;
         if (flush) begin
            flush  <= 1'b0;
            active <= 1'b0;
            owed   <= '0;
         end else if (take) begin
            owed   <= owed_nxt;
            active <= (owed_nxt != '0);
            // the rest sits in the holdover, so no further beat comes
            flush  <= (owed_nxt != '0) && (owed_nxt <= dw_count_t'(skew));
         end else if (start) begin
            active <= 1'b1;
            owed   <= owed_e;
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (take) begin
         held <= data;
         word <= align_word(held_e, data, skew, owed_e);
      end else begin
         if (start)
            held <= '0;
         // flush word, holdover followed by zero fill
         if (flush)
            word <= align_word(held, '0, skew, owed);
      end
   end

endmodule

//--- tlp_header_decode.sv
// a length field of 0 with the payload bit set is taken as 0 DWs, not 1024
`timescale 1ns/1ps
`include "pcie_tx_macros.svh"

module tlp_header_decode
   import pcie_tx_pkg::*;
(
   input  logic      clk_in,
   input  logic      rstn,
   input  logic      ack,
   input  word_t     desc,
   input  logic      err,
   input  logic      word_wr,
   output hdr_info_t hdr,
   output dw_count_t dw_left,
   output logic      busy
);

   localparam dw_count_t WORD_DWS = dw_count_t'(`TX_DW_PER_WORD);

   logic      has_pay;
   logic      is_4dw;
   logic      addr_b2;
   logic      pad;
   tlp_len_t  len;
   dw_count_t hdr_dws;
   dw_count_t total;
   word_t     hdr_word;
   dw_count_t left_dec;

   // ----------------------------------------
   // descriptor decode, used only at ack
   // ----------------------------------------

   assign has_pay = desc[`DESC_HAS_PAYLOAD_BIT];
   assign is_4dw  = desc[`DESC_4DW_BIT];

   // address lives in dw2 or dw3 depending on header form
   assign addr_b2 = is_4dw ? desc[`DESC_ADDR4_B2_BIT] : desc[`DESC_ADDR3_B2_BIT];

   // pad keeps the first payload DW qword aligned in the stream
   // 3DW: pad when bit 2 clear, 4DW: pad when bit 2 set
   assign pad = has_pay & (is_4dw ? addr_b2 : ~addr_b2);

   // length only counts when there is a payload
   assign len = has_pay ? desc[`DESC_LEN_LSB +: `DESC_LEN_W] : '0;

   assign hdr_dws = is_4dw ? dw_count_t'(4) : dw_count_t'(3);
   assign total   = hdr_dws + dw_count_t'(pad) + dw_count_t'(len);

   // 3DW form leaves dw3 zero, filled later by the pad or by payload dw0
   assign hdr_word = is_4dw ? desc : {desc[127:32], dw_t'(0)};

   // one stream word leaves per write, floor at zero
   assign left_dec = (dw_left > WORD_DWS) ? dw_left - WORD_DWS : '0;

   // ----------------------------------------
   // header capture
   // ----------------------------------------

   always_ff @(posedge clk_in) begin
      if (ack) begin
         hdr.has_payload <= has_pay;
         hdr.is_4dw      <= is_4dw;
         hdr.pad         <= pad;
         // only the 3DW form without pad has room for a payload DW
         hdr.carry_dws   <= has_pay & ~is_4dw & addr_b2;
         hdr.err         <= err;
         hdr.hdr_word    <= hdr_word;
      end
   end

   // ----------------------------------------
   // remaining stream DWs
   // ----------------------------------------

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         dw_left <= '0;
         busy    <= 1'b0;
      end else begin
         if (ack) begin
            // header alone is 3 DWs, so a packet always starts busy
            dw_left <= total;
            busy    <= 1'b1;
         end else if (word_wr) begin
            dw_left <= left_dec;
            busy    <= (left_dec != '0);
         end
      end
   end

endmodule

//--- pcie_tx_pkg.sv
// types of the tx stream path; widths follow the constants in pcie_tx_macros.svh
`include "pcie_tx_macros.svh"

package pcie_tx_pkg;

   // ----------------------------------------
   // plain vectors
   // ----------------------------------------

   // one doubleword
   typedef logic [31:0] dw_t;

   // one stream or payload word, dw0 of a beat sits in bits 31:0
   typedef logic [`TX_DW_PER_WORD*32-1:0] word_t;

   // payload length from the descriptor
   typedef logic [`DESC_LEN_W-1:0] tlp_len_t;

   // stream DWs still owed for a packet, header and pad included
   typedef logic [`DESC_LEN_W:0] dw_count_t;

   // ----------------------------------------
   // structs
   // ----------------------------------------

   // one buffer entry, first stream DW in data[127:96]
   typedef struct packed {
      logic  err;
      logic  sop;
      logic  eop;
      // last word holds 2 or fewer valid DWs
      logic  empty;
      word_t data;
   } stream_word_t;

   // decoded header, held from acknowledge until the next one
   typedef struct packed {
      logic  has_payload;
      logic  is_4dw;
      // a zero DW sits between header and payload
      logic  pad;
      // first payload DW shares the header word
      logic  carry_dws;
      logic  err;
      // header DWs in stream order, pad or payload slot still zero
      word_t hdr_word;
   } hdr_info_t;

endpackage

//--- pcie_tx_macros.svh
// tx stream path constants; TX_BUF_DEPTH must be a power of two and TX_BUF_AFULL below it
`ifndef PCIE_TX_MACROS_SVH
`define PCIE_TX_MACROS_SVH

// ----------------------------------------
// stream buffer
// ----------------------------------------

// entries in the stream word buffer
`define TX_BUF_DEPTH 64
// fill level that raises the wait state
// leaves room for words already in flight
`define TX_BUF_AFULL 48

// doublewords per 128-bit stream word
`define TX_DW_PER_WORD 4

// ----------------------------------------
// descriptor fields
// ----------------------------------------

// fmt bits of header dw0
`define DESC_HAS_PAYLOAD_BIT 126
`define DESC_4DW_BIT 125
// length field of header dw0, in DWs
`define DESC_LEN_LSB 96
`define DESC_LEN_W 10
// address bit 2, from dw2 for 3DW headers and from dw3 for 4DW headers
`define DESC_ADDR3_B2_BIT 34
`define DESC_ADDR4_B2_BIT 2

`endif
